//--- vlog.f
+incdir+design
design/axi_lite_pkg.sv
design/avmm_pkg.sv
design/avmm_req_if.sv
design/axi_lite_to_avmm.sv
design/avmm_req_fifo.sv
design/mmio_csr_afu.sv
design/mmio_afu_top.sv
tb/tb_mmio_afu.sv

//--- Bender.yml
package:
  name: mmio_afu

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/axi_lite_pkg.sv
      - design/avmm_pkg.sv
      - design/avmm_req_if.sv
      - design/axi_lite_to_avmm.sv
      - design/avmm_req_fifo.sv
      - design/mmio_csr_afu.sv
      - design/mmio_afu_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - tb/tb_mmio_afu.sv

//--- tb/tb_mmio_afu.sv
/*
 * Testbench of the MMIO AFU
 * Clock, reset, AXI-Lite stimulus tasks, shadow model, protocol assertions and watchdog
 */
`timescale 1ns/1ps
`default_nettype none
`include "mmio_defines.svh"

module tb_mmio_afu;
    import axi_lite_pkg::*;
    import avmm_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS  = 6;

    logic                      clk;
    logic                      arst_n;
    logic                      awvalid;
    logic                      awready;
    axi_addr_t                 awaddr;
    logic                      wvalid;
    logic                      wready;
    logic [`MMIO_DATA_W-1:0]   wdata;
    logic [`MMIO_DATA_W/8-1:0] wstrb;
    logic                      bvalid;
    logic                      bready;
    axi_resp_e                 bresp;
    logic                      arvalid;
    logic                      arready;
    axi_addr_t                 araddr;
    logic                      rvalid;
    logic                      rready;
    logic [`MMIO_DATA_W-1:0]   rdata;
    axi_resp_e                 rresp;

    // Shadow copy of the register map as the host expects it
    logic [`MMIO_DATA_W-1:0] shadow [`MMIO_CSR_COUNT];
    int                      write_count;
    int                      errors;
    int                      checks;
    int                      tests_run;
    int                      errors_at_start;
    integer                  seed;
    string                   test_name;
    event                    aw_done;

    mmio_afu_top DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Host side readiness for B and R beats changes at random every cycle
    always @(posedge clk) begin
        #1;
        bready = $random(seed);
        rready = $random(seed);
    end

    // ========================================================
    // Protocol assertions
    // ========================================================

    // Protocol violations count as errors and are described in plain words
    task automatic report_violation(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    a_reset_idle: assert property (@(posedge clk)
        !arst_n |-> !bvalid && !rvalid && !awready && !wready && !arready)
        else report_violation("Handshake output high while reset is held");
    a_idle_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !bvalid && !rvalid)
        else report_violation("bvalid or rvalid high right after reset");
    a_b_stable: assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else report_violation("B response dropped or changed before bready");
    a_r_stable: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else report_violation("R response dropped or changed before rready");
    a_b_after_write: assert property (@(posedge clk) disable iff (!arst_n)
        awvalid && awready && wvalid && wready |=> bvalid)
        else report_violation("No B response one cycle after an accepted write");
    a_b_only_after_write: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(bvalid) |-> $past(awvalid && awready))
        else report_violation("B response raised without an accepted write");

    // ========================================================
    // Shadow model and checking
    // ========================================================

    function automatic logic [`MMIO_DATA_W-1:0] expected_read(input int idx);
        if (idx == int'(CSR_AFU_ID)) return `MMIO_AFU_ID;
        if (idx == int'(CSR_WR_COUNT)) return `MMIO_DATA_W'(write_count);
        if (idx < `MMIO_CSR_COUNT) return shadow[idx];
        return '0;
    endfunction

    // Every write counts; only scratch registers take data, byte by byte
    task automatic model_write(input int idx, input logic [63:0] data, input logic [7:0] strb);
        write_count++;
        if (idx >= int'(CSR_SCRATCH) && idx < `MMIO_CSR_COUNT) begin
            for (int b = 0; b < 8; b++) begin
                if (strb[b]) shadow[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic compare_word(input string what, input logic [63:0] exp, input logic [63:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, got);
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        $display("Test %-18s %s", test_name, (errors == errors_at_start) ? "ok" : "had errors");
    endtask

    // ========================================================
    // AXI-Lite stimulus tasks that start and end 1 ns after a rising edge
    // ========================================================

    task automatic axi_write(input int idx, input logic [63:0] data, input logic [7:0] strb);
        logic done;
        awaddr  = axi_addr_t'(idx * 8);
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        done    = 1'b0;
        // Handshakes are sampled at the falling edge where the inputs have settled
        while (!done) begin
            @(negedge clk);
            done = awready && wready;
            @(posedge clk);
        end
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        model_write(idx, data, strb);
        ->aw_done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = bvalid && bready;
            if (done) compare_word("bresp", 64'(OKAY), 64'(bresp));
            @(posedge clk);
        end
        #1;
    endtask

    task automatic axi_read(input int idx);
        logic                    done;
        logic [`MMIO_DATA_W-1:0] exp;
        exp     = expected_read(idx);
        araddr  = axi_addr_t'(idx * 8);
        arvalid = 1'b1;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = arready;
            @(posedge clk);
        end
        #1;
        arvalid = 1'b0;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = rvalid && rready;
            if (done) begin
                compare_word($sformatf("rdata[%0d]", idx), exp, rdata);
                compare_word("rresp", 64'(OKAY), 64'(rresp));
            end
            @(posedge clk);
        end
        #1;
    endtask

    // Ends a hung run after a budget of 200 cycles per test
    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("Timeout: the DUT stopped answering and the tests did not finish");
        $display("Verification failed");
        $finish;
    end

    initial begin
        int idx;
        clk     = 1'b0;
        arst_n  = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        seed        = 32'h96f;
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        write_count = 0;
        for (int i = 0; i < `MMIO_CSR_COUNT; i++) shadow[i] = '0;
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(posedge clk);
        #1;

        start_test("afu_id_read");
        axi_read(int'(CSR_AFU_ID));
        finish_test();

        start_test("partial_strobe");
        axi_write(2, 64'h0123_4567_89ab_cdef, 8'hff);
        axi_write(2, 64'hfedc_ba98_7654_3210, 8'b0101_1010);
        axi_read(2);
        finish_test();

        // Writes to the read-only counter and past the map still count
        start_test("write_count");
        axi_write(int'(CSR_WR_COUNT), 64'hdead_beef, 8'hff);
        axi_write(32, 64'h1111_2222, 8'hff);
        axi_read(int'(CSR_WR_COUNT));
        finish_test();

        start_test("read_only_and_range");
        axi_read(64);
        axi_write(int'(CSR_AFU_ID), 64'h0, 8'hff);
        axi_read(int'(CSR_AFU_ID));
        finish_test();

        // Mixed traffic over the whole map and four words past it
        start_test("random_traffic");
        repeat (16) begin
            idx = $unsigned($random(seed)) % 12;
            if ($random(seed) & 1) axi_write(idx, {$random(seed), $random(seed)}, $random(seed));
            else axi_read(idx);
        end
        finish_test();

        // The read enters the FIFO while the last write may still be queued
        start_test("raw_ordering");
        axi_write(5, 64'haaaa_0000_aaaa_0000, 8'hff);
        axi_write(5, 64'hbbbb_1111_bbbb_1111, 8'h0f);
        fork
            axi_write(5, 64'hcccc_2222_cccc_2222, 8'hff);
            begin
                @(aw_done);
                axi_read(5);
            end
        join
        finish_test();

        $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/mmio_afu_top.sv
/*
 * Top level of the MMIO AFU
 * AXI-Lite bridge, request FIFO and CSR block
 */
`timescale 1ns/1ps
`default_nettype none
`include "mmio_defines.svh"

module mmio_afu_top (
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    input  wire logic                      awvalid,
    output logic                           awready,
    input  wire axi_lite_pkg::axi_addr_t   awaddr,
    input  wire logic                      wvalid,
    output logic                           wready,
    input  wire logic [`MMIO_DATA_W-1:0]   wdata,
    input  wire logic [`MMIO_DATA_W/8-1:0] wstrb,
    output logic                           bvalid,
    input  wire logic                      bready,
    output axi_lite_pkg::axi_resp_e        bresp,
    input  wire logic                      arvalid,
    output logic                           arready,
    input  wire axi_lite_pkg::axi_addr_t   araddr,
    output logic                           rvalid,
    input  wire logic                      rready,
    output logic [`MMIO_DATA_W-1:0]        rdata,
    output axi_lite_pkg::axi_resp_e        rresp
);

    // Bridge to FIFO and FIFO to CSR request links
    avmm_req_if fifo_in ();
    avmm_req_if fifo_out ();

    // Read return path from the CSR block back to the bridge
    logic                    csr_rdvalid;
    logic [`MMIO_DATA_W-1:0] csr_rdata;

    axi_lite_to_avmm u_bridge (
        .clk           (clk),
        .arst_n        (arst_n),
        .awvalid       (awvalid),
        .awready       (awready),
        .awaddr        (awaddr),
        .wvalid        (wvalid),
        .wready        (wready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .bvalid        (bvalid),
        .bready        (bready),
        .bresp         (bresp),
        .arvalid       (arvalid),
        .arready       (arready),
        .araddr        (araddr),
        .rvalid        (rvalid),
        .rready        (rready),
        .rdata         (rdata),
        .rresp         (rresp),
        .req           (fifo_in.source),
        .readdatavalid (csr_rdvalid),
        .readdata      (csr_rdata)
    );

    avmm_req_fifo #(
        .T     (avmm_pkg::avmm_req_t),
        .DEPTH (`MMIO_FIFO_DEPTH)
    ) u_fifo (
        .clk    (clk),
        .arst_n (arst_n),
        .enq    (fifo_in.sink),
        .deq    (fifo_out.source)
    );

    mmio_csr_afu u_csr (
        .clk           (clk),
        .arst_n        (arst_n),
        .req           (fifo_out.sink),
        .readdatavalid (csr_rdvalid),
        .readdata      (csr_rdata)
    );

endmodule

`default_nettype wire

//--- design/mmio_csr_afu.sv
/*
 * CSR block of the AFU
 * Identifier, write counter and byte-enabled scratch registers
 */
`timescale 1ns/1ps
`default_nettype none
`include "mmio_defines.svh"

module mmio_csr_afu (
    input  wire logic               clk,
    input  wire logic               arst_n,
    avmm_req_if.sink                req,
    output logic                    readdatavalid,
    output logic [`MMIO_DATA_W-1:0] readdata
);
    import avmm_pkg::*;

    localparam int IDX_W = $clog2(`MMIO_CSR_COUNT);
    localparam int SCR_N = `MMIO_CSR_COUNT - int'(CSR_SCRATCH);

    logic [`MMIO_DATA_W-1:0] scratch [SCR_N];
    logic [`MMIO_DATA_W-1:0] wr_count;
    logic [`MMIO_DATA_W-1:0] rd_value;
    csr_index_e              csr_sel;
    logic [IDX_W-1:0]        scr_idx;
    logic                    in_range;
    logic                    is_scratch;
    logic                    wr_take;
    logic                    rd_take;

    // Register accesses complete in one cycle so this block never stalls
    assign req.waitrequest = 1'b0;

    assign wr_take = req.valid && req.req.is_write;
    assign rd_take = req.valid && !req.req.is_write;

    // ========================================================
    // Address decode
    // ========================================================

    assign in_range   = (req.req.addr < AVMM_ADDR_W'(`MMIO_CSR_COUNT));
    assign csr_sel    = csr_index_e'(req.req.addr[IDX_W-1:0]);
    assign is_scratch = in_range && (csr_sel >= CSR_SCRATCH);
    assign scr_idx    = req.req.addr[IDX_W-1:0] - IDX_W'(CSR_SCRATCH);

    // Anything past the register map reads as zero
    always_comb begin
        rd_value = '0;
        if (in_range) begin
            case (csr_sel)
                CSR_AFU_ID:   rd_value = `MMIO_AFU_ID;
                CSR_WR_COUNT: rd_value = wr_count;
                default:      rd_value = scratch[scr_idx];
            endcase
        end
    end

    // ========================================================
    // Register state
    // ========================================================

    // Every accepted write bumps the counter, even one that hits a read-only
    // or unmapped address and so changes nothing else
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            readdatavalid <= 1'b0;
            wr_count      <= '0;
            for (int i = 0; i < SCR_N; i++) begin
                scratch[i] <= '0;
            end
        end else begin
            readdatavalid <= rd_take;
            if (wr_take) begin
                wr_count <= wr_count + 1'b1;
            end
            if (wr_take && is_scratch) begin
                // Merge only the byte lanes the host enabled
                for (int b = 0; b < AVMM_BE_W; b++) begin
                    if (req.req.byteenable[b]) begin
                        scratch[scr_idx][8*b +: 8] <= req.req.writedata[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_take) begin
            readdata <= rd_value;
        end
    end

    // Only one read is ever in flight, so return beats never come back to back
    a_one_beat_per_read: assert property (
        @(posedge clk) disable iff (!arst_n)
        readdatavalid |=> !readdatavalid
    );

endmodule

`default_nettype wire

//--- design/avmm_req_fifo.sv
/*
 * Request FIFO for any payload type
 * Stalls the producer with waitrequest while full
 */
`timescale 1ns/1ps
`default_nettype none
`include "mmio_defines.svh"

module avmm_req_fifo #(
    parameter type T     = avmm_pkg::avmm_req_t,
    parameter int  DEPTH = `MMIO_FIFO_DEPTH
) (
    input  wire logic  clk,
    input  wire logic  arst_n,
    avmm_req_if.sink   enq,
    avmm_req_if.source deq
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Pointers wrap at DEPTH so the depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        ptr_inc = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign enq.waitrequest = (count == CNT_W'(DEPTH));
    assign push            = enq.valid && !enq.waitrequest;

    // Head entry is offered whenever anything is stored
    assign deq.valid = (count != '0);
    assign deq.req   = mem[rd_ptr];
    assign pop       = deq.valid && !deq.waitrequest;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= enq.req;
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (!arst_n) count <= CNT_W'(DEPTH)
    );

    // Stored entries run from the read pointer up to the write pointer, so a push
    // never lands on an entry that has not been read yet
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        int'(wr_ptr) == (int'(rd_ptr) + int'(count)) % DEPTH
    );

endmodule

`default_nettype wire

//--- design/axi_lite_to_avmm.sv
/*
 * AXI-Lite to Avalon-MM bridge
 * Queues requests toward the FIFO and answers B locally and R from readdata
 */
`timescale 1ns/1ps
`default_nettype none
`include "mmio_defines.svh"

module axi_lite_to_avmm (
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    input  wire logic                      awvalid,
    output logic                           awready,
    input  wire axi_lite_pkg::axi_addr_t   awaddr,
    input  wire logic                      wvalid,
    output logic                           wready,
    input  wire logic [`MMIO_DATA_W-1:0]   wdata,
    input  wire logic [`MMIO_DATA_W/8-1:0] wstrb,
    output logic                           bvalid,
    input  wire logic                      bready,
    output axi_lite_pkg::axi_resp_e        bresp,
    input  wire logic                      arvalid,
    output logic                           arready,
    input  wire axi_lite_pkg::axi_addr_t   araddr,
    output logic                           rvalid,
    input  wire logic                      rready,
    output logic [`MMIO_DATA_W-1:0]        rdata,
    output axi_lite_pkg::axi_resp_e        rresp,
    avmm_req_if.source                     req,
    input  wire logic                      readdatavalid,
    input  wire logic [`MMIO_DATA_W-1:0]   readdata
);
    import axi_lite_pkg::*;
    import avmm_pkg::*;

    logic      wr_want;
    logic      rd_want;
    logic      wr_take;
    logic      rd_take;
    logic      rd_outstanding;
    avmm_req_t req_next;

    // ========================================================
    // Request side
    // ========================================================

    // A write needs its address and data beats together and no B beat waiting
    assign wr_want = awvalid && wvalid && !bvalid;
    // Only one read may be in flight at a time
    assign rd_want = arvalid && !rd_outstanding;

    // Writes win when both channels want the single FIFO port
    assign wr_take = wr_want && !req.waitrequest;
    assign rd_take = rd_want && !wr_want && !req.waitrequest;

    assign awready = wr_take;
    assign wready  = wr_take;
    assign arready = rd_take;

    // Byte address becomes a word address by dropping the lane bits
    always_comb begin
        req_next.is_write = wr_want;
        if (wr_want) begin
            req_next.addr       = awaddr[`MMIO_ADDR_W-1:AVMM_BYTE_SHIFT];
            req_next.byteenable = wstrb;
        end else begin
            req_next.addr       = araddr[`MMIO_ADDR_W-1:AVMM_BYTE_SHIFT];
            req_next.byteenable = '1;
        end
        req_next.writedata = wdata;
    end

    assign req.valid = wr_want || rd_want;
    assign req.req   = req_next;

    // ========================================================
    // Response side
    // ========================================================

    assign bresp = OKAY;
    assign rresp = OKAY;

    // The write is answered as soon as the FIFO has taken it
    // The read stays outstanding until its R beat has been handed over
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bvalid         <= 1'b0;
            rvalid         <= 1'b0;
            rd_outstanding <= 1'b0;
        end else begin
            if (wr_take) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (readdatavalid) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (rd_take) begin
                rd_outstanding <= 1'b1;
            end else if (rvalid && rready) begin
                rd_outstanding <= 1'b0;
            end
        end
    end

    // Read data is captured once and held for the R channel
    always_ff @(posedge clk) begin
        if (readdatavalid) begin
            rdata <= readdata;
        end
    end

    // The CSR block returns data only for a read this bridge issued and
    // never while the previous R beat is still waiting on the host
    a_rdv_needs_read: assert property (
        @(posedge clk) disable iff (!arst_n)
        readdatavalid |-> rd_outstanding && !rvalid
    );

endmodule

`default_nettype wire

//--- design/avmm_req_if.sv
/*
 * Avalon request channel with source and sink modports
 */
`timescale 1ns/1ps
`default_nettype none

interface avmm_req_if #(
    parameter type T = avmm_pkg::avmm_req_t
) ();

    // Request strobe, high while req holds a request to hand over
    logic valid;

    // Request payload, stable while valid waits on waitrequest
    T req;

    // Sink stall, a request moves only while this is low
    logic waitrequest;

    // The side that issues requests
    modport source (
        output valid,
        output req,
        input  waitrequest
    );

    // The side that takes requests
    modport sink (
        input  valid,
        input  req,
        output waitrequest
    );

endinterface

`default_nettype wire

//--- design/avmm_pkg.sv
/*
 * Avalon-MM package
 * Request struct carried through the FIFO and the CSR index map
 */
`default_nettype none
`include "mmio_defines.svh"

package avmm_pkg;

    // Low address bits that select a byte inside one data word
    localparam int AVMM_BYTE_SHIFT = $clog2(`MMIO_DATA_W / 8);
    localparam int AVMM_ADDR_W     = `MMIO_ADDR_W - AVMM_BYTE_SHIFT;
    localparam int AVMM_BE_W       = `MMIO_DATA_W / 8;

    // One read or write request in word addressing
    typedef struct packed {
        logic                    is_write;
        logic [AVMM_ADDR_W-1:0]  addr;
        logic [`MMIO_DATA_W-1:0] writedata;
        logic [AVMM_BE_W-1:0]    byteenable;
    } avmm_req_t;

    // Register map, scratch registers fill the rest of the CSR space
    typedef enum logic [$clog2(`MMIO_CSR_COUNT)-1:0] {
        CSR_AFU_ID   = 'd0,
        CSR_WR_COUNT = 'd1,
        CSR_SCRATCH  = 'd2
    } csr_index_e;

endpackage

`default_nettype wire

//--- design/axi_lite_pkg.sv
/*
 * AXI-Lite package
 * Response codes and the byte address type of the MMIO port
 */
`default_nettype none
`include "mmio_defines.svh"

package axi_lite_pkg;

    // Response codes as they appear on BRESP and RRESP
    // Only OKAY is ever produced by this AFU
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // Byte address as the host presents it
    typedef logic [`MMIO_ADDR_W-1:0] axi_addr_t;

endpackage

`default_nettype wire

//--- design/mmio_defines.svh
/*
 * Build constants of the MMIO AFU
 * Data and address widths, request FIFO depth, CSR count and AFU identifier
 */
`ifndef MMIO_DEFINES_SVH
`define MMIO_DEFINES_SVH

// One MMIO data word is 64 bits wide
`define MMIO_DATA_W 64

// Byte address width seen on the AXI-Lite port
`define MMIO_ADDR_W 16

// Number of requests the FIFO can hold between bridge and CSR block
`define MMIO_FIFO_DEPTH 4

// Number of 64-bit registers in the CSR map
`define MMIO_CSR_COUNT 8

// Constant that software reads back from register 0
`define MMIO_AFU_ID 64'h4d4d_494f_4146_5501

`endif
